// ==== hdl/cache_types_pkg.sv ====
`default_nettype none

package cache_types_pkg;

   localparam int TAG_BITS      = 21;
   localparam int INDEX_BITS    = 7;   // 128 sets
   localparam int WORD_SEL_BITS = 2;
   localparam int WORD_BITS     = 32;
   localparam int LINE_BITS     = 128; // four words per line

   typedef struct packed {
      logic [TAG_BITS-1:0]      tag;
      logic [INDEX_BITS-1:0]    index;
      logic [WORD_SEL_BITS-1:0] word_sel;
      logic [1:0]               byte_sel;  // always zero on the fetch port
   } addr_fields_t;

   typedef union packed {
      logic [31:0]  raw;
      addr_fields_t f;
   } cpu_addr_u;

   typedef logic way_t;

   typedef struct packed {
      logic                lru;    // least recently used way
      logic                valid1;
      logic [TAG_BITS-1:0] tag1;
      logic                valid0;
      logic [TAG_BITS-1:0] tag0;
   } tag_set_t;

endpackage

`default_nettype wire

// ==== hdl/cache_bus_pkg.sv ====
`default_nettype none

package cache_bus_pkg;

   typedef struct packed {
      logic                       strobe;
      cache_types_pkg::cpu_addr_u addr;
   } cpu_req_t;

   typedef struct packed {
      logic                                  valid;  // one-cycle pulse
      logic [cache_types_pkg::WORD_BITS-1:0] data;
      logic                                  hit;
   } cpu_resp_t;

   typedef struct packed {
      logic                                                             read;
      logic [cache_types_pkg::TAG_BITS+cache_types_pkg::INDEX_BITS-1:0] line_addr;
   } mem_req_t;

   typedef struct packed {
      logic                                  valid;
      logic [cache_types_pkg::LINE_BITS-1:0] line;
   } mem_resp_t;

endpackage

`default_nettype wire

// ==== hdl/sync_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_ram #(
   parameter int addr_width = 7,
   parameter int data_width = 21
) (
   input  wire                   clk,
   input  wire                   we,
   input  wire  [addr_width-1:0] addr,
   input  wire  [data_width-1:0] din,
   output logic [data_width-1:0] dout
);

   logic [data_width-1:0] mem [1 << addr_width];
   logic [addr_width-1:0] addr_q;

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= din;
      end
      addr_q <= addr;  // block ram style read
   end

   assign dout = mem[addr_q];

endmodule

`default_nettype wire

// ==== hdl/cache_tag_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tag_ram (
   input  wire                                    clk,
   input  wire                                    cache_reset,
   input  wire  [cache_types_pkg::INDEX_BITS-1:0] addr,
   input  wire  [1:0]                             we,
   input  wire                                    refill,
   input  wire  cache_types_pkg::tag_set_t        din,
   output cache_types_pkg::tag_set_t              dout
);
   import cache_types_pkg::*;

   localparam int SETS = 1 << INDEX_BITS;

   logic [1:0]            valid [SETS];
   logic                  lru   [SETS];
   logic [INDEX_BITS-1:0] addr_q;
   logic [TAG_BITS-1:0]   tag_in  [2];
   logic [TAG_BITS-1:0]   tag_out [2];

   assign tag_in[0] = din.tag0;
   assign tag_in[1] = din.tag1;

   for (genvar w = 0; w < 2; w++) begin : g_way
      sync_ram #(
         .addr_width(INDEX_BITS),
         .data_width(TAG_BITS)
      ) u_tag (
         .clk (clk),
         .we  (refill & we[w]),  // tags change only on refill
         .addr(addr),
         .din (tag_in[w]),
         .dout(tag_out[w])
      );
   end

   always_ff @(posedge clk) begin
      addr_q <= addr;  // keeps flop fields aligned with the ram output
   end

   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         for (int i = 0; i < SETS; i++) begin
            valid[i] <= 2'b00;
            lru[i]   <= 1'b0;
         end
      end else begin
         if (we[0]) begin
            valid[addr][0] <= din.valid0;
         end
         if (we[1]) begin
            valid[addr][1] <= din.valid1;
         end
         if (|we) begin
            lru[addr] <= din.lru;
         end
      end
   end

   assign dout = '{
      lru:    lru[addr_q],
      valid1: valid[addr_q][1],
      tag1:   tag_out[1],
      valid0: valid[addr_q][0],
      tag0:   tag_out[0]
   };

   // a refill replaces exactly one way
   a_refill_one_way: assert property (@(posedge clk) disable iff (!cache_reset)
      refill |-> $onehot(we));

endmodule

`default_nettype wire

// ==== hdl/cache_data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_data_ram (
   input  wire                                        clk,
   input  wire  [cache_types_pkg::INDEX_BITS-1:0]     addr,
   input  wire  [cache_types_pkg::WORD_SEL_BITS-1:0]  word_sel,
   input  wire  [1:0]                                 we,
   input  wire  [cache_types_pkg::LINE_BITS-1:0]      din,
   output logic [1:0][cache_types_pkg::WORD_BITS-1:0] dout
);
   import cache_types_pkg::*;

   logic [LINE_BITS-1:0]     line_out [2];
   logic [WORD_SEL_BITS-1:0] word_sel_q;

   always_ff @(posedge clk) begin
      word_sel_q <= word_sel;  // registered with the ram address
   end

   for (genvar w = 0; w < 2; w++) begin : g_way
      sync_ram #(
         .addr_width(INDEX_BITS),
         .data_width(LINE_BITS)
      ) u_line (
         .clk (clk),
         .we  (we[w]),
         .addr(addr),
         .din (din),
         .dout(line_out[w])
      );

      assign dout[w] = line_out[w][word_sel_q*WORD_BITS +: WORD_BITS];  // word 0 in low bits
   end

endmodule

`default_nettype wire

// ==== hdl/way_hit_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module way_hit_detect (
   input  wire cache_types_pkg::tag_set_t        set_entry,
   input  wire [cache_types_pkg::TAG_BITS-1:0]   req_tag,
   output logic                                  hit,
   output cache_types_pkg::way_t                 hit_way,
   output cache_types_pkg::way_t                 victim_way
);

   logic [1:0] way_match;

   assign way_match[0] = set_entry.valid0 && (set_entry.tag0 == req_tag);
   assign way_match[1] = set_entry.valid1 && (set_entry.tag1 == req_tag);

   assign hit     = |way_match;
   assign hit_way = way_match[1];  // both ways never hold the same tag

   // fill an empty way first, otherwise evict the lru way
   always_comb begin
      if (!set_entry.valid0) begin
         victim_way = 1'b0;
      end else if (!set_entry.valid1) begin
         victim_way = 1'b1;
      end else begin
         victim_way = set_entry.lru;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
   input  wire                                        clk,
   input  wire                                        cache_reset,
   input  wire  cache_bus_pkg::cpu_req_t              cpu_req,
   output cache_bus_pkg::cpu_resp_t                   cpu_resp,
   output logic                                       busy,
   output cache_bus_pkg::mem_req_t                    mem_req,
   input  wire  cache_bus_pkg::mem_resp_t             mem_resp,
   output logic [cache_types_pkg::INDEX_BITS-1:0]     set_index,
   output logic [cache_types_pkg::WORD_SEL_BITS-1:0]  word_sel,
   output logic [cache_types_pkg::TAG_BITS-1:0]       req_tag,
   input  wire                                        hit,
   input  wire  cache_types_pkg::way_t                hit_way,
   input  wire  cache_types_pkg::way_t                victim_way,
   input  wire                                        stored_lru,
   input  wire  [1:0][cache_types_pkg::WORD_BITS-1:0] way_data,
   output logic [1:0]                                 tag_we,
   output logic                                       refill,
   output cache_types_pkg::tag_set_t                  tag_wdata,
   output logic [cache_types_pkg::LINE_BITS-1:0]      line_wdata
);
   import cache_types_pkg::*;

   typedef enum logic [2:0] {idle, lookup, compare, wait_mem, respond} state_t;

   state_t               state;
   cpu_addr_u            req_q;
   logic                 read_q;
   logic                 resp_hit_q;
   logic [WORD_BITS-1:0] resp_data_q;
   way_t                 fill_way_q;
   way_t                 upd_way;
   logic                 accept;
   logic                 fill;
   logic [WORD_BITS-1:0] fill_word;

   // respond doubles as a ready state while the response pulse is out
   assign busy   = !(state == idle || state == respond);
   assign accept = cpu_req.strobe && !busy;
   assign fill   = (state == wait_mem) && mem_resp.valid;

   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         state  <= idle;
         read_q <= 1'b0;
      end else begin
         read_q <= 1'b0;
         case (state)
            idle, respond: state <= accept ? lookup : idle;
            lookup:        state <= compare;  // set read in flight
            compare: begin
               if (hit) begin
                  state <= respond;
               end else begin
                  state  <= wait_mem;
                  read_q <= 1'b1;
               end
            end
            wait_mem: begin
               if (mem_resp.valid) begin
                  state <= respond;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   assign fill_word = mem_resp.line[req_q.f.word_sel*WORD_BITS +: WORD_BITS];

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= cpu_req.addr;
      end
      if (state == compare) begin
         fill_way_q  <= victim_way;
         resp_hit_q  <= hit;
         resp_data_q <= way_data[hit_way];
      end
      if (fill) begin
         resp_data_q <= fill_word;  // answer straight from the arriving line
      end
   end

   // hit only touches lru, and only if it points at the way just used
   always_comb begin
      tag_we = 2'b00;
      refill = 1'b0;
      if (state == compare && hit && stored_lru == hit_way) begin
         tag_we[hit_way] = 1'b1;
      end
      if (fill) begin
         tag_we[fill_way_q] = 1'b1;
         refill             = 1'b1;
      end
   end

   assign upd_way = (state == wait_mem) ? fill_way_q : hit_way;

   assign tag_wdata = '{
      lru:    ~upd_way,
      valid1: 1'b1,
      tag1:   req_q.f.tag,
      valid0: 1'b1,
      tag0:   req_q.f.tag
   };

   assign line_wdata = mem_resp.line;
   assign set_index  = req_q.f.index;
   assign word_sel   = req_q.f.word_sel;
   assign req_tag    = req_q.f.tag;

   assign cpu_resp = '{valid: state == respond, data: resp_data_q, hit: resp_hit_q};
   assign mem_req  = '{read: read_q, line_addr: {req_q.f.tag, req_q.f.index}};

   // memory answers only the read we issued
   a_mem_resp_expected: assert property (@(posedge clk) disable iff (!cache_reset)
      mem_resp.valid |-> state == wait_mem);

   a_no_strobe_busy: assert property (@(posedge clk) disable iff (!cache_reset)
      cpu_req.strobe |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
   input  wire                              clk,
   input  wire                              cache_reset,
   input  wire  cache_bus_pkg::cpu_req_t    cpu_req,
   output cache_bus_pkg::cpu_resp_t         cpu_resp,
   output logic                             busy,
   output cache_bus_pkg::mem_req_t          mem_req,
   input  wire  cache_bus_pkg::mem_resp_t   mem_resp
);
   import cache_types_pkg::*;

   logic [INDEX_BITS-1:0]          set_index;
   logic [WORD_SEL_BITS-1:0]       word_sel;
   logic [TAG_BITS-1:0]            req_tag;
   logic                           hit;
   way_t                           hit_way;
   way_t                           victim_way;
   tag_set_t                       set_entry;
   tag_set_t                       tag_wdata;
   logic [1:0][WORD_BITS-1:0]      way_data;
   logic [1:0]                     tag_we;
   logic [1:0]                     data_we;
   logic                           refill;
   logic [LINE_BITS-1:0]           line_wdata;

   assign data_we = tag_we & {2{refill}};  // data changes on refill only

   cache_ctrl u_ctrl (
      .clk        (clk),
      .cache_reset(cache_reset),
      .cpu_req    (cpu_req),
      .cpu_resp   (cpu_resp),
      .busy       (busy),
      .mem_req    (mem_req),
      .mem_resp   (mem_resp),
      .set_index  (set_index),
      .word_sel   (word_sel),
      .req_tag    (req_tag),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .stored_lru (set_entry.lru),
      .way_data   (way_data),
      .tag_we     (tag_we),
      .refill     (refill),
      .tag_wdata  (tag_wdata),
      .line_wdata (line_wdata)
   );

   cache_tag_ram u_tag_ram (
      .clk        (clk),
      .cache_reset(cache_reset),
      .addr       (set_index),
      .we         (tag_we),
      .refill     (refill),
      .din        (tag_wdata),
      .dout       (set_entry)
   );

   cache_data_ram u_data_ram (
      .clk     (clk),
      .addr    (set_index),
      .word_sel(word_sel),
      .we      (data_we),
      .din     (line_wdata),
      .dout    (way_data)
   );

   way_hit_detect u_hit (
      .set_entry (set_entry),
      .req_tag   (req_tag),
      .hit       (hit),
      .hit_way   (hit_way),
      .victim_way(victim_way)
   );

endmodule

`default_nettype wire

// ==== verification/line_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_mem_model (
   input  wire                           clk,
   input  wire                           cache_reset,
   input  wire  cache_bus_pkg::mem_req_t mem_req,
   output cache_bus_pkg::mem_resp_t      mem_resp
);
   import cache_types_pkg::*;
   import cache_bus_pkg::*;

   mem_resp_t                      resp_q      = '0;
   logic                           pending     = 1'b0;
   int unsigned                    wait_left   = 0;
   logic [TAG_BITS+INDEX_BITS-1:0] line_addr_q = '0;

   function automatic logic [WORD_BITS-1:0] word_at(input logic [31:0] raw);
      return {raw[15:0], ~raw[31:16]} ^ 32'hC3A5_5A3C;  // every address bit shows in the word
   endfunction

   function automatic logic [LINE_BITS-1:0] line_at(
      input logic [TAG_BITS+INDEX_BITS-1:0] line_addr
   );
      return {word_at({line_addr, 2'd3, 2'b00}), word_at({line_addr, 2'd2, 2'b00}),
              word_at({line_addr, 2'd1, 2'b00}), word_at({line_addr, 2'd0, 2'b00})};
   endfunction

   always @(posedge clk) begin
      if (!cache_reset) begin
         resp_q  <= '0;
         pending <= 1'b0;
      end else begin
         resp_q.valid <= 1'b0;
         if (mem_req.read) begin
            pending     <= 1'b1;
            wait_left   <= $urandom_range(8, 1);
            line_addr_q <= mem_req.line_addr;
         end else if (pending) begin
            if (wait_left <= 1) begin
               resp_q  <= '{valid: 1'b1, line: line_at(line_addr_q)};
               pending <= 1'b0;
            end else begin
               wait_left <= wait_left - 1;
            end
         end
      end
   end

   assign mem_resp = resp_q;

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;
   import cache_types_pkg::*;
   import cache_bus_pkg::*;

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_READS = 24;
   localparam int ENTRY_CYCLES = 20;  // budget per table entry for the watchdog
   localparam logic [TAG_BITS-1:0] TAG_A = 21'h00123;
   localparam logic [TAG_BITS-1:0] TAG_B = 21'h1ABCD;
   localparam logic [TAG_BITS-1:0] TAG_C = 21'h0F0F0;
   localparam logic [TAG_BITS-1:0] TAG_D = 21'h10001;

   typedef struct packed {
      logic      is_reset;
      cpu_addr_u addr;
      logic      exp_hit;
      logic      from_model;  // hit flag taken from the reference model
   } stim_t;

   logic                clk         = 1'b0;
   logic                cache_reset = 1'b0;
   cpu_req_t            cpu_req     = '0;
   cpu_resp_t           cpu_resp;
   logic                busy;
   mem_req_t            mem_req;
   mem_resp_t           mem_resp;
   logic                table_built = 1'b0;
   stim_t               stim_table [$];
   logic [TAG_BITS-1:0] model_tag   [1 << INDEX_BITS][2];
   logic [1:0]          model_valid [1 << INDEX_BITS];
   way_t                model_lru   [1 << INDEX_BITS];

   always #HALF_PERIOD clk = ~clk;

   cache_top UUT (
      .clk        (clk),
      .cache_reset(cache_reset),
      .cpu_req    (cpu_req),
      .cpu_resp   (cpu_resp),
      .busy       (busy),
      .mem_req    (mem_req),
      .mem_resp   (mem_resp)
   );

   line_mem_model u_mem (
      .clk        (clk),
      .cache_reset(cache_reset),
      .mem_req    (mem_req),
      .mem_resp   (mem_resp)
   );

   function automatic logic [WORD_BITS-1:0] expected_word(input logic [31:0] raw);
      return {raw[15:0], ~raw[31:16]} ^ 32'hC3A5_5A3C;
   endfunction

   function automatic cpu_addr_u make_addr(input logic [TAG_BITS-1:0] tag,
                                           input logic [INDEX_BITS-1:0] index,
                                           input logic [WORD_SEL_BITS-1:0] word);
      cpu_addr_u a;
      a.f.tag      = tag;
      a.f.index    = index;
      a.f.word_sel = word;
      a.f.byte_sel = 2'b00;
      return a;
   endfunction

   function automatic void model_clear();
      model_valid = '{default: 2'b00};
      model_lru   = '{default: 1'b0};
   endfunction

   // two-way lru lookup that returns the hit flag and updates the model
   function automatic logic model_access(input cpu_addr_u addr);
      logic [INDEX_BITS-1:0] idx;
      logic                  hit;
      way_t                  way;
      idx = addr.f.index;
      hit = 1'b0;
      if (model_valid[idx][0] && model_tag[idx][0] == addr.f.tag) begin
         hit = 1'b1;
         way = 1'b0;
      end else if (model_valid[idx][1] && model_tag[idx][1] == addr.f.tag) begin
         hit = 1'b1;
         way = 1'b1;
      end else if (!model_valid[idx][0]) begin
         way = 1'b0;
      end else if (!model_valid[idx][1]) begin
         way = 1'b1;
      end else begin
         way = model_lru[idx];
      end
      if (!hit) begin
         model_valid[idx][way] = 1'b1;
         model_tag[idx][way]   = addr.f.tag;
      end
      model_lru[idx] = ~way;
      return hit;
   endfunction

   function automatic void push_read(input logic [TAG_BITS-1:0] tag,
                                     input logic [INDEX_BITS-1:0] index,
                                     input logic [WORD_SEL_BITS-1:0] word,
                                     input logic exp_hit);
      stim_t entry;
      entry            = '0;
      entry.addr       = make_addr(tag, index, word);
      entry.exp_hit    = exp_hit;
      stim_table.push_back(entry);
   endfunction

   function automatic void queue_reset();
      stim_t entry;
      entry          = '0;
      entry.is_reset = 1'b1;
      stim_table.push_back(entry);
   endfunction

   function automatic void append_random_reads(input int count);
      logic [TAG_BITS-1:0]   tag_pool   [4];
      logic [INDEX_BITS-1:0] index_pool [4];
      stim_t                 entry;
      tag_pool   = '{TAG_A, TAG_B, TAG_C, TAG_D};
      index_pool = '{7'h05, 7'h2A, 7'h7F, 7'h40};
      for (int i = 0; i < count; i++) begin
         entry            = '0;
         entry.addr       = make_addr(tag_pool[2'($urandom_range(3, 0))],
                                      index_pool[2'($urandom_range(3, 0))],
                                      2'($urandom_range(3, 0)));
         entry.from_model = 1'b1;
         stim_table.push_back(entry);
      end
   endfunction

   function automatic void build_table();
      push_read(TAG_A, 7'h05, 2'd0, 1'b0);  // cold miss
      push_read(TAG_A, 7'h05, 2'd0, 1'b1);
      push_read(TAG_A, 7'h05, 2'd3, 1'b1);  // other word, same line
      push_read(TAG_B, 7'h05, 2'd1, 1'b0);  // second tag on set 5
      push_read(TAG_A, 7'h05, 2'd2, 1'b1);
      push_read(TAG_B, 7'h05, 2'd0, 1'b1);  // tag a is now lru
      push_read(TAG_C, 7'h05, 2'd1, 1'b0);  // evicts tag a
      push_read(TAG_B, 7'h05, 2'd3, 1'b1);
      push_read(TAG_C, 7'h05, 2'd2, 1'b1);
      push_read(TAG_A, 7'h05, 2'd0, 1'b0);  // evicted line misses and b goes out
      push_read(TAG_B, 7'h05, 2'd1, 1'b0);
      push_read(TAG_A, 7'h7F, 2'd1, 1'b0);
      push_read(TAG_A, 7'h7F, 2'd1, 1'b1);
      queue_reset();
      push_read(TAG_A, 7'h05, 2'd0, 1'b0);  // nothing survives the reset
      push_read(TAG_B, 7'h05, 2'd3, 1'b0);
      push_read(TAG_A, 7'h7F, 2'd1, 1'b0);
      push_read(TAG_B, 7'h05, 2'd2, 1'b1);
      append_random_reads(RANDOM_READS);
   endfunction

   task automatic end_with_failure();
      $display("Checks failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_error(input string why);
      $display("ERROR at %t: %s", $time, why);
      end_with_failure();
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %t: %s expected %0b got %0b", $time, name, expected, actual);
         end_with_failure();
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("CHECK FAILED at %t: %s expected %0d got %0d", $time, name, expected, actual);
         end_with_failure();
      end
   endtask

   task automatic check_resp(input cpu_resp_t expected, input cpu_resp_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %t: cpu_resp expected valid=%0b data=%h hit=%0b %s",
                  $time, expected.valid, expected.data, expected.hit,
                  $sformatf("got valid=%0b data=%h hit=%0b",
                            actual.valid, actual.data, actual.hit));
         end_with_failure();
      end
   endtask

   task automatic check_mem_req(input mem_req_t expected, input mem_req_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %t: mem_req expected read=%0b line_addr=%h %s",
                  $time, expected.read, expected.line_addr,
                  $sformatf("got read=%0b line_addr=%h", actual.read, actual.line_addr));
         end_with_failure();
      end
   endtask

   task automatic run_reset();
      @(posedge clk);
      cache_reset <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      cache_reset <= 1'b1;
      model_clear();
      @(negedge clk);
      check_bit("busy", 1'b0, busy);
      check_bit("cpu_resp.valid", 1'b0, cpu_resp.valid);
      check_bit("mem_req.read", 1'b0, mem_req.read);
   endtask

   task automatic run_read(input cpu_addr_u req_addr, input logic exp_hit);
      int        cycles;
      int        reads;
      mem_req_t  exp_req;
      cpu_resp_t exp_resp;
      cycles   = 0;
      reads    = 0;
      exp_req  = '{read: 1'b1, line_addr: req_addr.raw[31:4]};
      exp_resp = '{valid: 1'b1, data: expected_word(req_addr.raw), hit: exp_hit};
      @(posedge clk);
      cpu_req <= '{strobe: 1'b1, addr: req_addr};
      @(posedge clk);
      cpu_req.strobe <= 1'b0;  // strobe taken at this edge
      do begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
         if (mem_req.read) begin
            reads++;
            check_mem_req(exp_req, mem_req);
         end
         if (!cpu_resp.valid) begin
            check_bit("busy", 1'b1, busy);
         end
      end while (!cpu_resp.valid);
      check_resp(exp_resp, cpu_resp);
      check_bit("busy", 1'b0, busy);
      check_count("memory reads", exp_hit ? 0 : 1, reads);
      if (exp_hit) begin
         check_count("hit latency in cycles", 2, cycles);
      end
   endtask

   initial begin
      logic model_hit;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(71520));
      build_table();
      table_built = 1'b1;
      run_reset();
      for (int i = 0; i < stim_table.size(); i++) begin
         if (stim_table[i].is_reset) begin
            run_reset();
         end else begin
            model_hit = model_access(stim_table[i].addr);
            if (!stim_table[i].from_model && model_hit != stim_table[i].exp_hit) begin
               report_error($sformatf("table entry %0d expects hit=%0b, reference model gives %0b",
                                      i, stim_table[i].exp_hit, model_hit));
            end
            run_read(stim_table[i].addr, model_hit);
         end
      end
      $display("All checks passed");
      $finish;
   end

   initial begin
      int limit_cycles;
      wait (table_built);
      limit_cycles = stim_table.size() * ENTRY_CYCLES + RESET_CYCLES + 4;
      repeat (limit_cycles) @(posedge clk);
      $display("TIMEOUT: the stimulus table did not finish within %0d cycles", limit_cycles);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/cache_types_pkg.sv
hdl/cache_bus_pkg.sv
hdl/sync_ram.sv
hdl/cache_tag_ram.sv
hdl/cache_data_ram.sv
hdl/way_hit_detect.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verification/line_mem_model.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module cache_tb -f src.f -o cache_sim

sim_output=$(./obj_dir/cache_sim) || true
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -q '^All checks passed$'; then
   exit 0
else
   exit 1
fi
